// ==== run_sim.sh ====
#!/bin/bash
# Build the CPU memory subsystem testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cpu_mem_top -f sources.f -o tb_cpu_mem_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu_mem_top > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
echo "simulation finished cleanly"
exit 0

// ==== sources.f ====
verilog/fsab_pkg.sv
verilog/dcache.sv
verilog/icache.sv
verilog/fsab_arbiter.sv
verilog/fsab_sram.sv
verilog/cpu_mem_top.sv
verification/tb_cpu_mem_top.sv

// ==== verification/tb_cpu_mem_top.sv ====
// Testbench for the CPU memory subsystem
// Drives both caches from the core side and checks every taken read against
// a shadow of memory with concurrent assertions. Covers read misses and hits,
// write hits and misses, line replacement, mixed instruction and data
// traffic, and a write burst that runs out of bus credits.

module tb_cpu_mem_top;

	localparam int RESET_CYCLES = 8;
	localparam int SEED = 45604;
	localparam int BUS_CREDITS = 4;
	localparam int N_READS = 6;
	localparam int N_MIX = 16;
	localparam int N_BURST = 3 * BUS_CREDITS; // long enough to exhaust the credits
	localparam int ACCESSES = 3 * N_READS + 9 + 2 * N_MIX + 2 * N_BURST;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * ACCESSES;

	logic clk;
	logic rst;
	logic [31:0] dc_addr;
	logic dc_rd_req;
	logic dc_wr_req;
	logic [31:0] dc_wr_data;
	logic dc_wait;
	logic [31:0] dc_rd_data;
	logic [31:0] ic_addr;
	logic ic_rd_req;
	logic ic_wait;
	logic [31:0] ic_rd_data;

	logic [31:0] shadow [2048]; // one entry per word of the 8 KB memory
	logic [31:0] dc_expect;
	logic [31:0] ic_expect;
	int stall_cycles;

	logic [31:0] mix_addr [N_MIX];
	logic mix_write [N_MIX];
	logic [31:0] mix_data [N_MIX];
	logic [31:0] fetch_addr [N_MIX];
	logic [31:0] burst_addr [N_BURST];

	cpu_mem_top #(
		.CACHE_LINES_LOG2(4),
		.BUS_CREDITS(BUS_CREDITS),
		.MEM_BEATS_LOG2(10)
	) cpu_mem_top_inst (
		.clk(clk), .rst(rst),
		.dc_addr(dc_addr), .dc_rd_req(dc_rd_req), .dc_wr_req(dc_wr_req),
		.dc_wr_data(dc_wr_data), .dc_wait(dc_wait), .dc_rd_data(dc_rd_data),
		.ic_addr(ic_addr), .ic_rd_req(ic_rd_req), .ic_wait(ic_wait),
		.ic_rd_data(ic_rd_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	assign dc_expect = shadow[dc_addr[12:2]];
	assign ic_expect = ic_addr ^ 32'h5A5A0000; // instruction words are never written

	dc_read_check: assert property (@(posedge clk) disable iff (rst)
		(dc_rd_req && !dc_wait) |-> (dc_rd_data == dc_expect))
		else begin
			$display("ERROR at %0t: dc_rd_data expected %h, actual %h",
				$time, dc_expect, dc_rd_data);
			$display("Test failed");
			$fatal(1, "data cache read mismatch");
		end

	ic_read_check: assert property (@(posedge clk) disable iff (rst)
		(ic_rd_req && !ic_wait) |-> (ic_rd_data == ic_expect))
		else begin
			$display("ERROR at %0t: ic_rd_data expected %h, actual %h",
				$time, ic_expect, ic_rd_data);
			$display("Test failed");
			$fatal(1, "instruction cache read mismatch");
		end

	dc_idle_check: assert property (@(posedge clk) disable iff (rst)
		(!dc_rd_req && !dc_wr_req) |-> !dc_wait)
		else begin
			$display("ERROR at %0t: dc_wait expected 0, actual %b", $time, dc_wait);
			$display("Test failed");
			$fatal(1, "data cache waits with no request");
		end

	ic_idle_check: assert property (@(posedge clk) disable iff (rst)
		!ic_rd_req |-> !ic_wait)
		else begin
			$display("ERROR at %0t: ic_wait expected 0, actual %b", $time, ic_wait);
			$display("Test failed");
			$fatal(1, "instruction cache waits with no request");
		end

	// word-aligned address in the lowest words*4 bytes
	function automatic logic [31:0] pick_addr(input int unsigned words);
		return ($urandom % words) << 2;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// wait is stable between edges, so it is looked at on the falling edge
	task automatic wait_taken(input logic instr);
		@(negedge clk);
		while (instr ? ic_wait : dc_wait) begin
			if (!instr)
				stall_cycles = stall_cycles + 1;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic read_data(input logic [31:0] addr);
		dc_addr = addr;
		dc_rd_req = 1'b1;
		wait_taken(1'b0);
		dc_rd_req = 1'b0;
	endtask

	task automatic write_data(input logic [31:0] addr, input logic [31:0] data);
		dc_addr = addr;
		dc_wr_data = data;
		dc_wr_req = 1'b1;
		wait_taken(1'b0);
		shadow[addr[12:2]] = data; // the write was taken on the last edge
		dc_wr_req = 1'b0;
	endtask

	task automatic fetch_instr(input logic [31:0] addr);
		ic_addr = addr;
		ic_rd_req = 1'b1;
		wait_taken(1'b1);
		ic_rd_req = 1'b0;
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] c;
		int burst_stalls;
		void'($urandom(SEED));
		for (int i = 0; i < 2048; i++)
			shadow[i] = (32'(i) << 2) ^ 32'h5A5A0000;
		rst = 1'b1;
		dc_addr = '0;
		dc_rd_req = 1'b0;
		dc_wr_req = 1'b0;
		dc_wr_data = '0;
		ic_addr = '0;
		ic_rd_req = 1'b0;
		stall_cycles = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
		idle_cycles(4);

		for (int i = 0; i < N_READS; i++) begin
			a = pick_addr(1024);
			read_data(a); // first access misses
			read_data(a);
			read_data(a ^ 32'h4); // other word of the same beat
		end

		a = pick_addr(1024);
		read_data(a);
		write_data(a, $urandom); // line is present, so the write hits
		read_data(a);
		a = a ^ 32'h800; // same index with another tag misses
		write_data(a, $urandom);
		read_data(a);
		c = pick_addr(1024);
		write_data(c, $urandom);
		read_data(c);
		read_data(c ^ 32'h400); // conflicting tag replaces the line
		read_data(c);

		// data and instruction traffic drawn up front, then run side by side
		for (int i = 0; i < N_MIX; i++) begin
			mix_addr[i] = pick_addr(256);
			mix_write[i] = 1'($urandom % 2);
			mix_data[i] = $urandom;
			fetch_addr[i] = 32'h1000 | pick_addr(64);
		end
		fork
			begin
				for (int i = 0; i < N_MIX; i++) begin
					if (mix_write[i])
						write_data(mix_addr[i], mix_data[i]);
					else
						read_data(mix_addr[i]);
				end
			end
			begin
				for (int i = 0; i < N_MIX; i++)
					fetch_instr(fetch_addr[i]);
			end
		join

		stall_cycles = 0;
		for (int i = 0; i < N_BURST; i++) begin
			burst_addr[i] = pick_addr(1024);
			write_data(burst_addr[i], $urandom);
		end
		burst_stalls = stall_cycles;
		for (int i = 0; i < N_BURST; i++)
			read_data(burst_addr[i]);
		idle_cycles(4);

		if (burst_stalls == 0) begin
			$display("the write burst never stalled on bus credits");
			$display("Test failed");
			$fatal(1, "no credit stall seen");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired at %0t: a held request never saw wait go low", $time);
		$display("Test failed");
		$fatal(1, "simulation timeout");
	end

endmodule

// ==== verilog/cpu_mem_top.sv ====
// CPU memory subsystem
// Data and instruction caches sharing one FSAB bus through the arbiter,
// with a block-RAM memory target behind it.

module cpu_mem_top #(
	parameter int CACHE_LINES_LOG2 = 4,
	parameter int BUS_CREDITS = 4,
	parameter int MEM_BEATS_LOG2 = 10
) (
	input  logic clk,
	input  logic rst,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] dc_addr,
	input  logic dc_rd_req,
	input  logic dc_wr_req,
	input  logic [31:0] dc_wr_data,
	output logic dc_wait,
	output logic [31:0] dc_rd_data,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] ic_addr,
	input  logic ic_rd_req,
	output logic ic_wait,
	output logic [31:0] ic_rd_data
);

	logic dc_want;
	logic dc_mode;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] dc_req_addr;
	logic [fsab_pkg::FSAB_MASK_W-1:0] dc_mask;
	fsab_pkg::fsab_beat_t dc_data;
	logic dc_grant;
	logic dc_fill_valid;
	logic ic_want;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] ic_req_addr;
	logic ic_grant;
	logic ic_fill_valid;
	fsab_pkg::fsab_beat_t fill_beat;

	logic bus_req_valid;
	logic bus_req_mode;
	logic bus_req_did;
	logic [fsab_pkg::FSAB_ADDR_W-1:0] bus_req_addr;
	logic [fsab_pkg::FSAB_MASK_W-1:0] bus_req_mask;
	fsab_pkg::fsab_beat_t bus_req_data;
	logic bus_credit;
	logic mem_fill_valid;
	logic mem_fill_did;
	fsab_pkg::fsab_beat_t mem_fill_data;

	dcache #(.CACHE_LINES_LOG2(CACHE_LINES_LOG2)) dcache_inst (
		.clk(clk), .rst(rst),
		.dc_addr(dc_addr), .dc_rd_req(dc_rd_req), .dc_wr_req(dc_wr_req),
		.dc_wr_data(dc_wr_data), .dc_wait(dc_wait), .dc_rd_data(dc_rd_data),
		.want(dc_want), .req_mode(dc_mode), .req_addr(dc_req_addr),
		.req_mask(dc_mask), .req_data(dc_data), .grant(dc_grant),
		.fill_valid(dc_fill_valid), .fill_data(fill_beat)
	);

	icache #(.CACHE_LINES_LOG2(CACHE_LINES_LOG2)) icache_inst (
		.clk(clk), .rst(rst),
		.ic_addr(ic_addr), .ic_rd_req(ic_rd_req), .ic_wait(ic_wait),
		.ic_rd_data(ic_rd_data), .want(ic_want), .req_addr(ic_req_addr),
		.grant(ic_grant), .fill_valid(ic_fill_valid), .fill_data(fill_beat)
	);

	fsab_arbiter #(.BUS_CREDITS(BUS_CREDITS)) fsab_arbiter_inst (
		.clk(clk), .rst(rst),
		.dc_want(dc_want), .dc_mode(dc_mode), .dc_addr(dc_req_addr),
		.dc_mask(dc_mask), .dc_data(dc_data),
		.ic_want(ic_want), .ic_addr(ic_req_addr),
		.dc_grant(dc_grant), .ic_grant(ic_grant),
		.bus_req_valid(bus_req_valid), .bus_req_mode(bus_req_mode),
		.bus_req_did(bus_req_did), .bus_req_addr(bus_req_addr),
		.bus_req_mask(bus_req_mask), .bus_req_data(bus_req_data),
		.bus_credit(bus_credit), .fill_valid(mem_fill_valid),
		.fill_did(mem_fill_did), .fill_data(mem_fill_data),
		.dc_fill_valid(dc_fill_valid), .ic_fill_valid(ic_fill_valid),
		.fill_beat(fill_beat)
	);

	fsab_sram #(
		.BUS_CREDITS(BUS_CREDITS),
		.MEM_BEATS_LOG2(MEM_BEATS_LOG2)
	) fsab_sram_inst (
		.clk(clk), .rst(rst),
		.bus_req_valid(bus_req_valid), .bus_req_mode(bus_req_mode),
		.bus_req_did(bus_req_did), .bus_req_addr(bus_req_addr),
		.bus_req_mask(bus_req_mask), .bus_req_data(bus_req_data),
		.bus_credit(bus_credit), .fill_valid(mem_fill_valid),
		.fill_did(mem_fill_did), .fill_data(mem_fill_data)
	);

endmodule

// ==== verilog/dcache.sv ====
// Data cache
// Direct-mapped, write-through, 64-byte lines filled as 8 bus beats.
// A read miss requests the whole line; every write goes to memory as one
// masked beat and also updates the line when it hits.

module dcache #(
	parameter int CACHE_LINES_LOG2 = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] dc_addr,
	input  logic dc_rd_req,
	input  logic dc_wr_req,
	input  logic [31:0] dc_wr_data,
	output logic dc_wait,
	output logic [31:0] dc_rd_data,
	output logic want,
	output logic req_mode,
	output logic [fsab_pkg::FSAB_ADDR_W-1:0] req_addr,
	output logic [fsab_pkg::FSAB_MASK_W-1:0] req_mask,
	output fsab_pkg::fsab_beat_t req_data,
	input  logic grant,
	input  logic fill_valid,
	input  fsab_pkg::fsab_beat_t fill_data
);

	localparam int LINES = 1 << CACHE_LINES_LOG2;
	localparam int POS_W = $clog2(fsab_pkg::LINE_BEATS);
	localparam int OFF_W = POS_W + 3;
	localparam int TAG_W = fsab_pkg::FSAB_ADDR_W - OFF_W - CACHE_LINES_LOG2;

	logic [LINES-1:0] line_valid;
	logic [TAG_W-1:0] line_tag [LINES];
	fsab_pkg::fsab_beat_t line_data [LINES*fsab_pkg::LINE_BEATS]; // {line, beat}

	logic [CACHE_LINES_LOG2-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [POS_W-1:0] word_sel;
	logic hit;
	logic start_read;
	logic start_write;
	logic fill_pending;
	logic [POS_W-1:0] fill_pos;
	logic [CACHE_LINES_LOG2-1:0] fill_idx;

	assign idx = dc_addr[OFF_W +: CACHE_LINES_LOG2];
	assign tag = dc_addr[fsab_pkg::FSAB_ADDR_W-1 -: TAG_W];
	assign word_sel = dc_addr[3 +: POS_W];
	assign hit = line_valid[idx] && (line_tag[idx] == tag);

	// address bit 2 picks the word inside the beat
	assign dc_rd_data = line_data[{idx, word_sel}].half[dc_addr[2]];

	// only one line read can be outstanding, and writes wait behind it
	assign start_read = dc_rd_req && !hit && !fill_pending;
	assign start_write = dc_wr_req && !dc_rd_req && !fill_pending;
	assign want = start_read || start_write;

	assign req_mode = start_read ? fsab_pkg::FSAB_READ : fsab_pkg::FSAB_WRITE;
	assign req_addr = start_read ? {dc_addr[fsab_pkg::FSAB_ADDR_W-1:OFF_W], {OFF_W{1'b0}}}
		: {dc_addr[fsab_pkg::FSAB_ADDR_W-1:3], 3'b000};
	assign req_mask = start_read ? '0 : {{4{dc_addr[2]}}, {4{~dc_addr[2]}}};
	assign req_data = {dc_wr_data, dc_wr_data}; // the mask picks the live half

	// a read holds until the line hits, a write until its grant
	assign dc_wait = dc_rd_req ? !hit : (dc_wr_req && !grant);

	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= '0;
			fill_pending <= 1'b0;
			fill_pos <= '0;
		end else if (grant && start_read) begin
			line_valid[idx] <= 1'b0; // old contents go away as the fill starts
			fill_pending <= 1'b1;
			fill_pos <= '0;
		end else if (fill_valid) begin
			fill_pos <= fill_pos + 1'b1;
			if (fill_pos == POS_W'(fsab_pkg::LINE_BEATS - 1)) begin
				line_valid[fill_idx] <= 1'b1;
				fill_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant && start_read) begin
			line_tag[idx] <= tag;
			fill_idx <= idx;
		end
		// fill beats and write hits never share a cycle since writes wait for the fill
		if (fill_valid)
			line_data[{fill_idx, fill_pos}] <= fill_data;
		else if (grant && start_write && hit)
			line_data[{idx, word_sel}].half[dc_addr[2]] <= dc_wr_data;
	end

	// the arbiter may only route beats here while a line read is outstanding
	a_fill_expected: assert property (@(posedge clk) disable iff (rst)
		fill_valid |-> fill_pending);

endmodule

// ==== verilog/fsab_arbiter.sv ====
// FSAB arbiter
// Shares the bus between the data and instruction caches round-robin.
// Owns the bus credits: one is spent per request strobe and one comes back
// per request the memory takes. Fill beats are steered back by requester ID.

module fsab_arbiter #(
	parameter int BUS_CREDITS = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic dc_want,
	input  logic dc_mode,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] dc_addr,
	input  logic [fsab_pkg::FSAB_MASK_W-1:0] dc_mask,
	input  fsab_pkg::fsab_beat_t dc_data,
	input  logic ic_want,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] ic_addr,
	output logic dc_grant,
	output logic ic_grant,
	output logic bus_req_valid,
	output logic bus_req_mode,
	output logic bus_req_did,
	output logic [fsab_pkg::FSAB_ADDR_W-1:0] bus_req_addr,
	output logic [fsab_pkg::FSAB_MASK_W-1:0] bus_req_mask,
	output fsab_pkg::fsab_beat_t bus_req_data,
	input  logic bus_credit,
	input  logic fill_valid,
	input  logic fill_did,
	input  fsab_pkg::fsab_beat_t fill_data,
	output logic dc_fill_valid,
	output logic ic_fill_valid,
	output fsab_pkg::fsab_beat_t fill_beat
);

	localparam int CRED_W = $clog2(BUS_CREDITS + 1);

	logic [CRED_W-1:0] credits;
	logic credit_avail;
	logic rr_ic; // set when the icache has priority

	assign credit_avail = (credits != '0);
	assign dc_grant = dc_want && credit_avail && (!ic_want || !rr_ic);
	assign ic_grant = ic_want && credit_avail && (!dc_want || rr_ic);

	assign bus_req_valid = dc_grant || ic_grant;
	assign bus_req_did = ic_grant ? fsab_pkg::FSAB_DID_ICACHE : fsab_pkg::FSAB_DID_DCACHE;
	assign bus_req_mode = ic_grant ? fsab_pkg::FSAB_READ : dc_mode;
	assign bus_req_addr = ic_grant ? ic_addr : dc_addr;
	assign bus_req_mask = ic_grant ? '0 : dc_mask;
	assign bus_req_data = dc_data; // icache requests are reads and ignore data

	assign dc_fill_valid = fill_valid && (fill_did == fsab_pkg::FSAB_DID_DCACHE);
	assign ic_fill_valid = fill_valid && (fill_did == fsab_pkg::FSAB_DID_ICACHE);
	assign fill_beat = fill_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CRED_W'(BUS_CREDITS);
			rr_ic <= 1'b0;
		end else begin
			credits <= credits + CRED_W'(bus_credit) - CRED_W'(bus_req_valid);
			if (bus_req_valid)
				rr_ic <= dc_grant; // the other side goes first next time
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(dc_grant && ic_grant));
	// the memory never returns more credits than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CRED_W'(BUS_CREDITS));

endmodule

// ==== verilog/fsab_pkg.sv ====
// FSAB bus package
// Shared widths, request modes and requester IDs for the split-transaction
// memory bus. It also holds the 64-bit beat type, which the caches read as
// two 32-bit words and the bus treats as one word.

package fsab_pkg;

	parameter int FSAB_ADDR_W = 32; // beat-aligned byte address
	parameter int FSAB_DATA_W = 64;
	parameter int FSAB_MASK_W = 8; // one bit per byte of a beat
	parameter int LINE_BEATS = 8; // a 64-byte line is 8 beats

	// request mode carried with every bus request
	parameter logic FSAB_READ = 1'b0;
	parameter logic FSAB_WRITE = 1'b1;

	// requester IDs, echoed back with every fill beat
	parameter logic FSAB_DID_DCACHE = 1'b0;
	parameter logic FSAB_DID_ICACHE = 1'b1;

	// One bus beat. Address bit 2 picks the 32-bit word, so half[1] is the
	// hi word and half[0] the lo word.
	typedef union packed {
		logic [FSAB_DATA_W-1:0] word; // whole beat as the bus sees it
		logic [1:0][FSAB_DATA_W/2-1:0] half; // word pair as the caches see it
	} fsab_beat_t;

endpackage

// ==== verilog/fsab_sram.sv ====
// FSAB block-RAM memory target
// Requests queue in a FIFO of BUS_CREDITS entries. The head entry is popped
// one cycle after it arrives there, which returns its credit. Writes apply
// the byte mask; reads stream 8 beats on consecutive cycles with the ID.

module fsab_sram #(
	parameter int BUS_CREDITS = 4,
	parameter int MEM_BEATS_LOG2 = 10
) (
	input  logic clk,
	input  logic rst,
	input  logic bus_req_valid,
	input  logic bus_req_mode,
	input  logic bus_req_did,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] bus_req_addr,
	input  logic [fsab_pkg::FSAB_MASK_W-1:0] bus_req_mask,
	input  fsab_pkg::fsab_beat_t bus_req_data,
	output logic bus_credit,
	output logic fill_valid,
	output logic fill_did,
	output fsab_pkg::fsab_beat_t fill_data
);

	localparam int PTR_W = (BUS_CREDITS > 1) ? $clog2(BUS_CREDITS) : 1;
	localparam int CNT_W = $clog2(BUS_CREDITS + 1);
	localparam int POS_W = $clog2(fsab_pkg::LINE_BEATS);

	fsab_pkg::fsab_beat_t mem [1 << MEM_BEATS_LOG2];

	logic q_mode [BUS_CREDITS];
	logic q_did [BUS_CREDITS];
	logic [MEM_BEATS_LOG2-1:0] q_addr [BUS_CREDITS];
	logic [fsab_pkg::FSAB_MASK_W-1:0] q_mask [BUS_CREDITS];
	fsab_pkg::fsab_beat_t q_data [BUS_CREDITS];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic head_ok;
	logic head_armed; // head entry has sat there for one cycle
	logic pop;
	logic [POS_W-1:0] beats_left;
	logic [MEM_BEATS_LOG2-1:0] burst_beat;
	logic [MEM_BEATS_LOG2-1:0] rd_beat;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(BUS_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	initial begin
		for (int i = 0; i < (1 << MEM_BEATS_LOG2); i++) begin
			mem[i].half[0] = (32'(i) << 3) ^ 32'h5A5A0000;
			mem[i].half[1] = ((32'(i) << 3) + 32'd4) ^ 32'h5A5A0000;
		end
	end

	// a running burst keeps the next request waiting at the head
	assign head_ok = (count != '0) && (beats_left == '0);
	assign pop = head_ok && head_armed;
	assign bus_credit = pop;
	assign rd_beat = (beats_left == '0) ? q_addr[rd_ptr] : burst_beat;

	always_ff @(posedge clk) begin
		if (bus_req_valid) begin
			q_mode[wr_ptr] <= bus_req_mode;
			q_did[wr_ptr] <= bus_req_did;
			q_addr[wr_ptr] <= bus_req_addr[3 +: MEM_BEATS_LOG2];
			q_mask[wr_ptr] <= bus_req_mask;
			q_data[wr_ptr] <= bus_req_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			head_armed <= 1'b0;
			beats_left <= '0;
			fill_valid <= 1'b0;
		end else begin
			if (bus_req_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			count <= count + CNT_W'(bus_req_valid) - CNT_W'(pop);
			head_armed <= head_ok && !pop;
			if (pop && (q_mode[rd_ptr] == fsab_pkg::FSAB_READ)) begin
				fill_valid <= 1'b1;
				beats_left <= POS_W'(fsab_pkg::LINE_BEATS - 1);
			end else if (beats_left != '0) begin
				fill_valid <= 1'b1;
				beats_left <= beats_left - 1'b1;
			end else begin
				fill_valid <= 1'b0;
			end
		end
	end

	// block RAM port, read every cycle and qualified by fill_valid
	always_ff @(posedge clk) begin
		fill_data <= mem[rd_beat];
		if (pop) begin
			fill_did <= q_did[rd_ptr];
			burst_beat <= q_addr[rd_ptr] + 1'b1;
		end else begin
			burst_beat <= burst_beat + 1'b1;
		end
		if (pop && (q_mode[rd_ptr] == fsab_pkg::FSAB_WRITE)) begin
			for (int b = 0; b < fsab_pkg::FSAB_MASK_W; b++) begin
				if (q_mask[rd_ptr][b])
					mem[q_addr[rd_ptr]].word[8*b +: 8] <= q_data[rd_ptr].word[8*b +: 8];
			end
		end
	end

	// holds only while the arbiter spends credits correctly
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		bus_req_valid |-> (count < CNT_W'(BUS_CREDITS)) || pop);

endmodule

// ==== verilog/icache.sv ====
// Instruction cache
// Direct-mapped, read-only, 64-byte lines filled as 8 bus beats.
// A miss asks the arbiter for a line read and holds the core until it hits.

module icache #(
	parameter int CACHE_LINES_LOG2 = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [fsab_pkg::FSAB_ADDR_W-1:0] ic_addr,
	input  logic ic_rd_req,
	output logic ic_wait,
	output logic [31:0] ic_rd_data,
	output logic want,
	output logic [fsab_pkg::FSAB_ADDR_W-1:0] req_addr,
	input  logic grant,
	input  logic fill_valid,
	input  fsab_pkg::fsab_beat_t fill_data
);

	localparam int LINES = 1 << CACHE_LINES_LOG2;
	localparam int POS_W = $clog2(fsab_pkg::LINE_BEATS);
	localparam int OFF_W = POS_W + 3;
	localparam int TAG_W = fsab_pkg::FSAB_ADDR_W - OFF_W - CACHE_LINES_LOG2;

	logic [LINES-1:0] line_valid;
	logic [TAG_W-1:0] line_tag [LINES];
	fsab_pkg::fsab_beat_t line_data [LINES*fsab_pkg::LINE_BEATS];

	logic [CACHE_LINES_LOG2-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;
	logic fill_pending;
	logic [POS_W-1:0] fill_pos;
	logic [CACHE_LINES_LOG2-1:0] fill_idx;

	assign idx = ic_addr[OFF_W +: CACHE_LINES_LOG2];
	assign tag = ic_addr[fsab_pkg::FSAB_ADDR_W-1 -: TAG_W];
	assign hit = line_valid[idx] && (line_tag[idx] == tag);

	assign ic_rd_data = line_data[{idx, ic_addr[3 +: POS_W]}].half[ic_addr[2]];
	assign ic_wait = ic_rd_req && !hit;

	assign want = ic_rd_req && !hit && !fill_pending;
	assign req_addr = {ic_addr[fsab_pkg::FSAB_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			line_valid <= '0;
			fill_pending <= 1'b0;
			fill_pos <= '0;
		end else if (grant) begin
			line_valid[idx] <= 1'b0;
			fill_pending <= 1'b1;
			fill_pos <= '0;
		end else if (fill_valid) begin
			fill_pos <= fill_pos + 1'b1;
			if (fill_pos == POS_W'(fsab_pkg::LINE_BEATS - 1)) begin
				line_valid[fill_idx] <= 1'b1; // hits from the next cycle on
				fill_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			line_tag[idx] <= tag;
			fill_idx <= idx;
		end
		if (fill_valid)
			line_data[{fill_idx, fill_pos}] <= fill_data;
	end

	a_fill_expected: assert property (@(posedge clk) disable iff (rst)
		fill_valid |-> fill_pending);

endmodule
